// File: hdl/rv_pkg.sv
// Shared RV64I definitions: opcodes, ALU/memory/branch encodings, control and commit structs
package rv_pkg;

  localparam int XLEN = 64;

  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_e;

  // Same values as the load/store funct3 field
  typedef enum logic [2:0] {
    MEM_B = 3'd0, MEM_H = 3'd1, MEM_W = 3'd2, MEM_D = 3'd3,
    MEM_BU = 3'd4, MEM_HU = 3'd5, MEM_WU = 3'd6
  } mem_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_sel_pc;   // pc as operand A
    logic       b_sel_imm;  // Immediate as operand B
    logic       word_cut;   // *W forms
    br_e        br;
    logic       mem_rd;
    logic       mem_wr;
    mem_op_e    mem_op;
    logic       reg_wr;
    logic [4:0] rd;
    logic       wb_pc4;     // Link value for jal/jalr
    logic       halt;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } commit_t;

endpackage

// File: hdl/rv_regfile.sv
// General register file, 32 x 64 bits, x0 reads as zero
`timescale 1ns/1ps

module rv_regfile (
  input  logic                    i_clk,
  input  logic                    i_we,
  input  logic [4:0]              i_rd,
  input  logic [rv_pkg::XLEN-1:0] i_wdata,
  input  logic [4:0]              i_rs1,
  input  logic [4:0]              i_rs2,
  output logic [rv_pkg::XLEN-1:0] o_rs1data,
  output logic [rv_pkg::XLEN-1:0] o_rs2data
);

  logic [rv_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // Entry 0 is never written
  assign o_rs1data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// File: hdl/rv_ifu.sv
// Fetch unit: pc register and instruction memory with load port
`timescale 1ns/1ps

module rv_ifu #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_step,
  input  logic [rv_pkg::XLEN-1:0] i_next_pc,
  input  logic                    i_imem_we,
  input  logic [7:0]              i_imem_addr,
  input  logic [31:0]             i_imem_data,
  output logic [rv_pkg::XLEN-1:0] o_pc,
  output logic [31:0]             o_inst
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [31:0] imem [IMEM_DEPTH];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc <= '0;
    end else if (i_step) begin
      o_pc <= i_next_pc;
    end
  end

  // Loaded by the host while the core is stopped
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr[AW-1:0]] <= i_imem_data;
    end
  end

  assign o_inst = imem[o_pc[AW+1:2]];  // Word index

endmodule

// File: hdl/rv_idu.sv
// Decode unit: control decoder, immediate generator and register file
`timescale 1ns/1ps

module rv_idu (
  input  logic                    i_clk,
  input  logic                    i_step,
  input  logic [31:0]             i_inst,
  input  logic [rv_pkg::XLEN-1:0] i_wb_data,
  output logic [rv_pkg::XLEN-1:0] o_rs1data,
  output logic [rv_pkg::XLEN-1:0] o_rs2data,
  output logic [rv_pkg::XLEN-1:0] o_imm,
  output rv_pkg::ctrl_t           o_ctrl
);

  import rv_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            is_reg;
  logic            is_word;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign is_reg  = (opcode == OP_REG) || (opcode == OP_REG32);
  assign is_word = (opcode == OP_IMM32) || (opcode == OP_REG32);

  always_comb begin
    o_ctrl    = '0;
    o_ctrl.rd = i_inst[11:7];
    o_imm     = imm_i;
    unique case (opcode)
      OP_LUI: begin
        o_ctrl.alu_op    = ALU_PASSB;
        o_ctrl.b_sel_imm = 1'b1;
        o_ctrl.reg_wr    = 1'b1;
        o_imm            = imm_u;
      end
      OP_AUIPC: begin
        o_ctrl.a_sel_pc  = 1'b1;
        o_ctrl.b_sel_imm = 1'b1;
        o_ctrl.reg_wr    = 1'b1;
        o_imm            = imm_u;
      end
      OP_JAL: begin
        o_ctrl.br     = BR_JAL;
        o_ctrl.wb_pc4 = 1'b1;
        o_ctrl.reg_wr = 1'b1;
        o_imm         = imm_j;
      end
      OP_JALR: begin
        o_ctrl.br        = BR_JALR;
        o_ctrl.b_sel_imm = 1'b1;  // ALU forms rs1+imm
        o_ctrl.wb_pc4    = 1'b1;
        o_ctrl.reg_wr    = 1'b1;
        o_ctrl.illegal   = (funct3 != 3'd0);
      end
      OP_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'd0:    o_ctrl.br = BR_BEQ;
          3'd1:    o_ctrl.br = BR_BNE;
          3'd4:    o_ctrl.br = BR_BLT;
          3'd5:    o_ctrl.br = BR_BGE;
          3'd6:    o_ctrl.br = BR_BLTU;
          3'd7:    o_ctrl.br = BR_BGEU;
          default: o_ctrl.illegal = 1'b1;
        endcase
      end
      OP_LOAD, OP_STORE: begin
        o_ctrl.b_sel_imm = 1'b1;
        o_ctrl.mem_rd    = (opcode == OP_LOAD);
        o_ctrl.reg_wr    = (opcode == OP_LOAD);
        o_ctrl.mem_wr    = (opcode == OP_STORE);
        o_ctrl.mem_op    = mem_op_e'(funct3);
        if (opcode == OP_STORE) begin
          o_imm = imm_s;
        end
        // No unsigned stores, no ldu
        o_ctrl.illegal = (funct3 == 3'd7) || ((opcode == OP_STORE) && funct3[2]);
      end
      OP_IMM, OP_IMM32, OP_REG, OP_REG32: begin
        o_ctrl.b_sel_imm = !is_reg;
        o_ctrl.word_cut  = is_word;
        o_ctrl.reg_wr    = 1'b1;
        case (funct3)
          3'd0:    o_ctrl.alu_op = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'd1:    o_ctrl.alu_op = ALU_SLL;
          3'd2:    o_ctrl.alu_op = ALU_SLT;
          3'd3:    o_ctrl.alu_op = ALU_SLTU;
          3'd4:    o_ctrl.alu_op = ALU_XOR;
          3'd5:    o_ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'd6:    o_ctrl.alu_op = ALU_OR;
          default: o_ctrl.alu_op = ALU_AND;
        endcase
        if (is_word && !(funct3 inside {3'd0, 3'd1, 3'd5})) begin
          o_ctrl.illegal = 1'b1;
        end
        if (is_reg && (funct7 != 7'h00) && !((funct7 == 7'h20) && (funct3 inside {3'd0, 3'd5}))) begin
          o_ctrl.illegal = 1'b1;
        end
      end
      OP_SYSTEM: begin
        o_ctrl.halt    = (i_inst == INST_EBREAK);
        o_ctrl.illegal = (i_inst != INST_EBREAK);  // ecall and CSR ops unsupported
      end
      default: o_ctrl.illegal = 1'b1;
    endcase
    // Unknown instructions leave no state behind
    if (o_ctrl.illegal) begin
      o_ctrl.reg_wr = 1'b0;
      o_ctrl.mem_wr = 1'b0;
      o_ctrl.mem_rd = 1'b0;
      o_ctrl.br     = BR_NONE;
    end
  end

  rv_regfile rv_regfile_inst (
    .i_clk     (i_clk),
    .i_we      (i_step && o_ctrl.reg_wr),
    .i_rd      (o_ctrl.rd),
    .i_wdata   (i_wb_data),
    .i_rs1     (i_inst[19:15]),
    .i_rs2     (i_inst[24:20]),
    .o_rs1data (o_rs1data),
    .o_rs2data (o_rs2data)
  );

endmodule

// File: hdl/rv_exu.sv
// Execute unit: ALU, branch compare, next-pc choice and writeback select
`timescale 1ns/1ps

module rv_exu (
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pkg::XLEN-1:0] i_rs1,
  input  logic [rv_pkg::XLEN-1:0] i_rs2,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  input  rv_pkg::ctrl_t           i_ctrl,
  input  logic [rv_pkg::XLEN-1:0] i_load_data,
  output logic [rv_pkg::XLEN-1:0] o_alu_result,
  output logic [rv_pkg::XLEN-1:0] o_next_pc,
  output logic [rv_pkg::XLEN-1:0] o_wb_data
);

  import rv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_r;
  logic [5:0]      shamt;
  logic [XLEN-1:0] pc4;
  logic [XLEN-1:0] br_tgt;
  logic            take;

  assign op_a   = i_ctrl.a_sel_pc ? i_pc : i_rs1;
  assign op_b   = i_ctrl.b_sel_imm ? i_imm : i_rs2;
  assign pc4    = i_pc + 64'd4;
  assign br_tgt = i_pc + i_imm;

  // Word forms shift only the low half
  always_comb begin
    alu_a = op_a;
    shamt = op_b[5:0];
    if (i_ctrl.word_cut) begin
      shamt = {1'b0, op_b[4:0]};
      alu_a = (i_ctrl.alu_op == ALU_SRA) ? {{32{op_a[31]}}, op_a[31:0]} : {32'b0, op_a[31:0]};
    end
  end

  always_comb begin
    unique case (i_ctrl.alu_op)
      ALU_SUB:   alu_r = alu_a - op_b;
      ALU_SLL:   alu_r = alu_a << shamt;
      ALU_SLT:   alu_r = {63'b0, $signed(alu_a) < $signed(op_b)};
      ALU_SLTU:  alu_r = {63'b0, alu_a < op_b};
      ALU_XOR:   alu_r = alu_a ^ op_b;
      ALU_SRL:   alu_r = alu_a >> shamt;
      ALU_SRA:   alu_r = $signed(alu_a) >>> shamt;
      ALU_OR:    alu_r = alu_a | op_b;
      ALU_AND:   alu_r = alu_a & op_b;
      ALU_PASSB: alu_r = op_b;
      default:   alu_r = alu_a + op_b;
    endcase
  end

  assign o_alu_result = i_ctrl.word_cut ? {{32{alu_r[31]}}, alu_r[31:0]} : alu_r;

  always_comb begin
    unique case (i_ctrl.br)
      BR_BEQ:  take = (i_rs1 == i_rs2);
      BR_BNE:  take = (i_rs1 != i_rs2);
      BR_BLT:  take = ($signed(i_rs1) < $signed(i_rs2));
      BR_BGE:  take = ($signed(i_rs1) >= $signed(i_rs2));
      BR_BLTU: take = (i_rs1 < i_rs2);
      BR_BGEU: take = (i_rs1 >= i_rs2);
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ctrl.halt || i_ctrl.illegal) begin
      o_next_pc = i_pc;  // Stay on the halting instruction
    end else if (i_ctrl.br == BR_JALR) begin
      o_next_pc = {o_alu_result[XLEN-1:1], 1'b0};
    end else if ((i_ctrl.br == BR_JAL) || take) begin
      o_next_pc = br_tgt;
    end else begin
      o_next_pc = pc4;
    end
  end

  assign o_wb_data = i_ctrl.mem_rd ? i_load_data : (i_ctrl.wb_pc4 ? pc4 : o_alu_result);

endmodule

// File: hdl/rv_lsu.sv
// Load/store unit: doubleword data memory, sized stores, extended loads
`timescale 1ns/1ps

module rv_lsu #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic                    i_clk,
  input  logic                    i_step,
  input  logic [rv_pkg::XLEN-1:0] i_addr,
  input  logic [rv_pkg::XLEN-1:0] i_wdata,
  input  rv_pkg::ctrl_t           i_ctrl,
  output logic [rv_pkg::XLEN-1:0] o_rdata
);

  import rv_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  logic [XLEN-1:0] dmem [DMEM_DEPTH];
  logic [AW-1:0]   idx;
  logic [2:0]      ofs;
  logic [XLEN-1:0] rd_sh;
  logic [XLEN-1:0] wd_sh;
  logic [7:0]      size_mask;
  logic [7:0]      lanes;

  assign idx   = i_addr[AW+2:3];
  assign ofs   = i_addr[2:0];
  assign rd_sh = dmem[idx] >> {ofs, 3'b000};
  assign wd_sh = i_wdata << {ofs, 3'b000};

  always_comb begin
    unique case (i_ctrl.mem_op)
      MEM_B, MEM_BU: size_mask = 8'h01;
      MEM_H, MEM_HU: size_mask = 8'h03;
      MEM_W, MEM_WU: size_mask = 8'h0f;
      default:       size_mask = 8'hff;
    endcase
  end

  assign lanes = size_mask << ofs;  // Accesses stay inside one doubleword

  always_ff @(posedge i_clk) begin
    if (i_step && i_ctrl.mem_wr) begin
      for (int i = 0; i < 8; i++) begin
        if (lanes[i]) dmem[idx][8*i +: 8] <= wd_sh[8*i +: 8];
      end
    end
  end

  always_comb begin
    unique case (i_ctrl.mem_op)
      MEM_B:   o_rdata = {{56{rd_sh[7]}}, rd_sh[7:0]};
      MEM_H:   o_rdata = {{48{rd_sh[15]}}, rd_sh[15:0]};
      MEM_W:   o_rdata = {{32{rd_sh[31]}}, rd_sh[31:0]};
      MEM_BU:  o_rdata = {56'b0, rd_sh[7:0]};
      MEM_HU:  o_rdata = {48'b0, rd_sh[15:0]};
      MEM_WU:  o_rdata = {32'b0, rd_sh[31:0]};
      default: o_rdata = rd_sh;
    endcase
  end

endmodule

// File: hdl/rv_core.sv
// Core top level: reset sync, halt state, unit wiring and commit port
`timescale 1ns/1ps

module rv_core #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_run,
  input  logic                    i_imem_we,
  input  logic [7:0]              i_imem_addr,
  input  logic [31:0]             i_imem_data,
  output logic                    o_commit_valid,
  output rv_pkg::commit_t         o_commit,
  output logic                    o_halt,
  output logic                    o_illegal,
  output logic [rv_pkg::XLEN-1:0] o_pc
);

  import rv_pkg::*;

  logic [1:0]      rst_sync;
  logic            rst_n;
  logic            step;
  logic [31:0]     inst;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] rs1data;
  logic [XLEN-1:0] rs2data;
  logic [XLEN-1:0] imm;
  ctrl_t           ctrl;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] load_data;

  // Async assert, release after two clocks
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) rst_sync <= '0;
    else          rst_sync <= {rst_sync[0], 1'b1};
  end
  assign rst_n = rst_sync[1];

  assign step = i_run && !o_halt;

  always_ff @(posedge i_clk or negedge rst_n) begin
    if (!rst_n) begin
      o_halt    <= 1'b0;
      o_illegal <= 1'b0;
    end else if (step && (ctrl.halt || ctrl.illegal)) begin
      o_halt    <= 1'b1;
      o_illegal <= ctrl.illegal;
    end
  end

  rv_ifu #(.IMEM_DEPTH(IMEM_DEPTH)) rv_ifu_inst (
    .i_clk (i_clk), .i_rst_n (rst_n), .i_step (step), .i_next_pc (next_pc),
    .i_imem_we (i_imem_we), .i_imem_addr (i_imem_addr), .i_imem_data (i_imem_data),
    .o_pc (o_pc), .o_inst (inst)
  );

  rv_idu rv_idu_inst (
    .i_clk (i_clk), .i_step (step), .i_inst (inst), .i_wb_data (wb_data),
    .o_rs1data (rs1data), .o_rs2data (rs2data), .o_imm (imm), .o_ctrl (ctrl)
  );

  rv_exu rv_exu_inst (
    .i_pc (o_pc), .i_rs1 (rs1data), .i_rs2 (rs2data), .i_imm (imm), .i_ctrl (ctrl),
    .i_load_data (load_data), .o_alu_result (alu_result), .o_next_pc (next_pc),
    .o_wb_data (wb_data)
  );

  rv_lsu #(.DMEM_DEPTH(DMEM_DEPTH)) rv_lsu_inst (
    .i_clk (i_clk), .i_step (step), .i_addr (alu_result), .i_wdata (rs2data),
    .i_ctrl (ctrl), .o_rdata (load_data)
  );

  assign o_commit_valid = step && ctrl.reg_wr && (ctrl.rd != 5'd0);
  assign o_commit       = '{pc: o_pc, rd: ctrl.rd, data: wb_data};

endmodule

// File: tests/tb_rv_core.sv
// Testbench for rv_core: program and expected-commit tables, commit checks, halt checks
`timescale 1ns/1ps

module tb_rv_core;

  import rv_pkg::*;

  localparam int          N_PROG         = 45;
  localparam int          COMMIT_TIMEOUT = 50;
  localparam int          HALT_TIMEOUT   = 50;
  localparam int          HOLD_CYCLES    = 20;
  localparam logic [63:0] HALT_PC        = 64'h0000_0000_0000_00b0;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_run;
  logic        i_imem_we;
  logic [7:0]  i_imem_addr;
  logic [31:0] i_imem_data;
  logic        o_commit_valid;
  commit_t     o_commit;
  logic        o_halt;
  logic        o_illegal;
  logic [63:0] o_pc;

  logic [63:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [63:0] exp_data [$];
  string       exp_name [$];
  int          n_pass;
  int          n_fail;

  // Word index i sits at pc 4*i
  logic [31:0] prog [N_PROG] = '{
    32'h06400093,  // 00 addi  x1, x0, 100
    32'hff900113,  // 04 addi  x2, x0, -7
    32'h002081b3,  // 08 add   x3, x1, x2
    32'h40110233,  // 0c sub   x4, x2, x1
    32'h02809293,  // 10 slli  x5, x1, 40
    32'h40115313,  // 14 srai  x6, x2, 1
    32'h03c15393,  // 18 srli  x7, x2, 60
    32'h00112433,  // 1c slt   x8, x2, x1
    32'h001134b3,  // 20 sltu  x9, x2, x1
    32'h0f00c513,  // 24 xori  x10, x1, 0xf0
    32'h0020e5b3,  // 28 or    x11, x1, x2
    32'h0020f633,  // 2c and   x12, x1, x2
    32'h7ffff6b7,  // 30 lui   x13, 0x7ffff
    32'h00d6873b,  // 34 addw  x14, x13, x13
    32'h00001797,  // 38 auipc x15, 0x1
    32'h80000837,  // 3c lui   x16, 0x80000
    32'h4048589b,  // 40 sraiw x17, x16, 4
    32'h10000a13,  // 44 addi  x20, x0, 0x100
    32'h004a3023,  // 48 sd    x4, 0(x20)
    32'h001a00a3,  // 4c sb    x1, 1(x20)
    32'h000a3a83,  // 50 ld    x21, 0(x20)
    32'h001a0b03,  // 54 lb    x22, 1(x20)
    32'h000a4b83,  // 58 lbu   x23, 0(x20)
    32'h000a0c03,  // 5c lb    x24, 0(x20)
    32'h000a1c83,  // 60 lh    x25, 0(x20)
    32'h002a5d03,  // 64 lhu   x26, 2(x20)
    32'h00da2423,  // 68 sw    x13, 8(x20)
    32'h008a2d83,  // 6c lw    x27, 8(x20)
    32'h002a2623,  // 70 sw    x2, 12(x20)
    32'h00ca2e03,  // 74 lw    x28, 12(x20)
    32'h00ca6e83,  // 78 lwu   x29, 12(x20)
    32'h001a1123,  // 7c sh    x1, 2(x20)
    32'h000a3f03,  // 80 ld    x30, 0(x20)
    32'h00108463,  // 84 beq   x1, x1, +8
    32'h00100f93,  // 88 addi  x31, x0, 1   skipped
    32'h008002ef,  // 8c jal   x5, +8
    32'h00200f93,  // 90 addi  x31, x0, 2   skipped
    32'h00109463,  // 94 bne   x1, x1, +8   not taken
    32'h0a000313,  // 98 addi  x6, x0, 0xa0
    32'h009303e7,  // 9c jalr  x7, 9(x6)    lands on 0xa8
    32'h00300f93,  // a0 addi  x31, x0, 3   skipped
    32'h00400f93,  // a4 addi  x31, x0, 4   skipped
    32'h00508013,  // a8 addi  x0, x1, 5    no commit
    32'h00100433,  // ac add   x8, x0, x1
    32'h00100073   // b0 ebreak
  };

  rv_core rv_core_inst (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_run          (i_run),
    .i_imem_we      (i_imem_we),
    .i_imem_addr    (i_imem_addr),
    .i_imem_data    (i_imem_data),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit),
    .o_halt         (o_halt),
    .o_illegal      (o_illegal),
    .o_pc           (o_pc)
  );

  always #4 i_clk = ~i_clk;

  task automatic expect_commit(input logic [63:0] pc, input logic [4:0] rd,
                               input logic [63:0] data, input string name);
    exp_pc.push_back(pc);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    exp_name.push_back(name);
  endtask

  // Values worked out by hand from the RV64I rules
  task automatic build_expected();
    expect_commit(64'h00, 5'd1,  64'h0000_0000_0000_0064, "addi");
    expect_commit(64'h04, 5'd2,  64'hffff_ffff_ffff_fff9, "addi_neg");
    expect_commit(64'h08, 5'd3,  64'h0000_0000_0000_005d, "add");
    expect_commit(64'h0c, 5'd4,  64'hffff_ffff_ffff_ff95, "sub");
    expect_commit(64'h10, 5'd5,  64'h0000_6400_0000_0000, "slli");
    expect_commit(64'h14, 5'd6,  64'hffff_ffff_ffff_fffc, "srai");
    expect_commit(64'h18, 5'd7,  64'h0000_0000_0000_000f, "srli");
    expect_commit(64'h1c, 5'd8,  64'h0000_0000_0000_0001, "slt");
    expect_commit(64'h20, 5'd9,  64'h0000_0000_0000_0000, "sltu");
    expect_commit(64'h24, 5'd10, 64'h0000_0000_0000_0094, "xori");
    expect_commit(64'h28, 5'd11, 64'hffff_ffff_ffff_fffd, "or");
    expect_commit(64'h2c, 5'd12, 64'h0000_0000_0000_0060, "and");
    expect_commit(64'h30, 5'd13, 64'h0000_0000_7fff_f000, "lui");
    expect_commit(64'h34, 5'd14, 64'hffff_ffff_ffff_e000, "addw_overflow");
    expect_commit(64'h38, 5'd15, 64'h0000_0000_0000_1038, "auipc");
    expect_commit(64'h3c, 5'd16, 64'hffff_ffff_8000_0000, "lui_neg");
    expect_commit(64'h40, 5'd17, 64'hffff_ffff_f800_0000, "sraiw");
    expect_commit(64'h44, 5'd20, 64'h0000_0000_0000_0100, "addi_base");
    expect_commit(64'h50, 5'd21, 64'hffff_ffff_ffff_6495, "ld_after_sb");
    expect_commit(64'h54, 5'd22, 64'h0000_0000_0000_0064, "lb_pos");
    expect_commit(64'h58, 5'd23, 64'h0000_0000_0000_0095, "lbu");
    expect_commit(64'h5c, 5'd24, 64'hffff_ffff_ffff_ff95, "lb_neg");
    expect_commit(64'h60, 5'd25, 64'h0000_0000_0000_6495, "lh");
    expect_commit(64'h64, 5'd26, 64'h0000_0000_0000_ffff, "lhu");
    expect_commit(64'h6c, 5'd27, 64'h0000_0000_7fff_f000, "lw_pos");
    expect_commit(64'h74, 5'd28, 64'hffff_ffff_ffff_fff9, "lw_neg");
    expect_commit(64'h78, 5'd29, 64'h0000_0000_ffff_fff9, "lwu");
    expect_commit(64'h80, 5'd30, 64'hffff_ffff_0064_6495, "ld_after_sh");
    expect_commit(64'h8c, 5'd5,  64'h0000_0000_0000_0090, "jal_link");
    expect_commit(64'h98, 5'd6,  64'h0000_0000_0000_00a0, "addi_jbase");
    expect_commit(64'h9c, 5'd7,  64'h0000_0000_0000_00a0, "jalr_link");
    expect_commit(64'hac, 5'd8,  64'h0000_0000_0000_0064, "x0_reads_zero");
  endtask

  task automatic tally(input bit ok, input string name);
    if (ok) begin
      n_pass++;
      $display("  ok    %s", name);
    end else begin
      n_fail++;
    end
  endtask

  task automatic check_commit(input int k);
    bit got;
    bit ok;
    int cyc;
    got = 1'b0;
    cyc = 0;
    while (!got && cyc < COMMIT_TIMEOUT) begin
      @(negedge i_clk);  // Commit port is settled mid-cycle
      got = o_commit_valid;
      cyc++;
    end
    ok = got && (o_commit.pc == exp_pc[k]) && (o_commit.rd == exp_rd[k]) &&
         (o_commit.data == exp_data[k]);
    assert (ok) else begin
      if (!got) begin
        $display("%s: no commit arrived within %0d cycles", exp_name[k], COMMIT_TIMEOUT);
      end else begin
        $display("** Error %s: expected pc=%h rd=%0d data=%h, actual pc=%h rd=%0d data=%h",
                 exp_name[k], exp_pc[k], exp_rd[k], exp_data[k],
                 o_commit.pc, o_commit.rd, o_commit.data);
      end
    end
    tally(ok, exp_name[k]);
  endtask

  task automatic check_halt();
    int cyc;
    cyc = 0;
    while (!o_halt && cyc < HALT_TIMEOUT) begin
      @(negedge i_clk);
      cyc++;
    end
    assert (o_halt && !o_illegal && (o_pc == HALT_PC)) else begin
      if (!o_halt) begin
        $display("ebreak_halt: halt was not raised within %0d cycles", HALT_TIMEOUT);
      end else begin
        $display("** Error ebreak_halt: expected illegal=0 pc=%h, actual illegal=%0b pc=%h",
                 HALT_PC, o_illegal, o_pc);
      end
    end
    tally(o_halt && !o_illegal && (o_pc == HALT_PC), "ebreak_halt");
  endtask

  // Nothing may move once halted
  task automatic check_hold();
    int          n_commits;
    logic [63:0] seen_pc;
    n_commits = 0;
    seen_pc   = HALT_PC;
    repeat (HOLD_CYCLES) begin
      @(negedge i_clk);
      if (o_commit_valid) n_commits++;
      if (o_pc != HALT_PC) seen_pc = o_pc;
    end
    assert ((n_commits == 0) && (seen_pc == HALT_PC)) else begin
      if (n_commits != 0) begin
        $display("halt_hold: %0d commits were seen after the core halted", n_commits);
      end else begin
        $display("** Error halt_hold: expected pc=%h, actual pc=%h", HALT_PC, seen_pc);
      end
    end
    tally((n_commits == 0) && (seen_pc == HALT_PC), "halt_hold");
  endtask

  initial begin
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_run       = 1'b0;
    i_imem_we   = 1'b0;
    i_imem_addr = 8'd0;
    i_imem_data = 32'd0;
    n_pass      = 0;
    n_fail      = 0;
    build_expected();
    repeat (2) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int i = 0; i < N_PROG; i++) begin
      @(posedge i_clk);
      i_imem_we   <= 1'b1;
      i_imem_addr <= 8'(i);
      i_imem_data <= prog[i];
    end
    @(posedge i_clk);
    i_imem_we <= 1'b0;
    i_run     <= 1'b1;
    for (int k = 0; k < exp_pc.size(); k++) begin
      check_commit(k);
    end
    check_halt();
    check_hold();
    $display("tests: %0d run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: rv_core.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_ifu.sv
hdl/rv_idu.sv
hdl/rv_exu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
tests/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_rv_core
FILELIST  := rv_core.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
